//--- common/guard_pkg.sv
// Write guard definitions
// Budget and age types, table index sizing and the fault cause record

`default_nettype none

package guard_pkg;

  // Budgets and tick counts share one width
  localparam int unsigned BudgetWidth = 10;

  typedef logic [BudgetWidth-1:0] budget_t;

  // Age carries one extra bit so it can pass the largest budget
  typedef logic [BudgetWidth:0] age_t;

  // Index width for a table of n entries, never below one bit
  function automatic int unsigned idx_width(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // Sticky fault reasons
  typedef struct packed {
    logic timeout;     // A write ran past its budget
    logic unknown_id;  // B response without a matching write
  } fault_cause_t;

endpackage

`default_nettype wire

//--- common/wr_bus_pkg.sv
// Write bus definitions
// Widths and types of the AW and B channel fields seen by the write guard

`default_nettype none

package wr_bus_pkg;

  // Transaction ID, one word shared by AW and B
  localparam int unsigned IdWidth = 4;

  // AW burst length field, beats minus one
  localparam int unsigned LenWidth = 8;

  typedef logic [IdWidth-1:0]  id_t;
  typedef logic [LenWidth-1:0] len_t;

endpackage

`default_nettype wire

//--- logic/aw_monitor.sv
// AW channel monitor
// Gates AW ready and turns each AW handshake into a one-cycle enqueue
// request carrying the ID and the budget of the write

`timescale 1ns/1ps
`default_nettype none

module aw_monitor (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                mst_aw_valid_i,
  input  wr_bus_pkg::id_t     mst_aw_id_i,
  input  wr_bus_pkg::len_t    mst_aw_len_i,
  input  logic                slv_aw_ready_i,
  input  guard_pkg::budget_t  budget_unit_i,
  input  logic                table_full_i,
  input  logic                fault_active_i,
  output logic                mst_aw_ready_o,
  output logic                enq_valid_o,
  output wr_bus_pkg::id_t     enq_id_o,
  output guard_pkg::budget_t  enq_budget_o
);

  import guard_pkg::*;

  logic                 aw_hs;
  logic [BudgetWidth:0] budget_sum;  // One bit wider to catch overflow
  budget_t              budget_sat;

  // No new writes while the table is full or a fault is pending
  assign mst_aw_ready_o = slv_aw_ready_i & ~table_full_i & ~fault_active_i;
  assign aw_hs          = mst_aw_valid_i & mst_aw_ready_o;

  // Longer bursts get a longer budget
  assign budget_sum = {1'b0, budget_unit_i} + (BudgetWidth + 1)'(mst_aw_len_i);
  assign budget_sat = budget_sum[BudgetWidth] ? '1 : budget_sum[BudgetWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enq_valid_o <= 1'b0;
    end else begin
      enq_valid_o <= aw_hs;  // Single-cycle request
    end
  end

  // Payload of the request
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      enq_id_o     <= mst_aw_id_i;
      enq_budget_o <= budget_sat;
    end
  end

endmodule

`default_nettype wire

//--- logic/fault_handler.sv
// Fault handler
// Collects fault causes, holds the reset request until software clears it
// and pulses the interrupt when a fault first appears

`timescale 1ns/1ps
`default_nettype none

module fault_handler (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    fault_valid_i,
  input  guard_pkg::fault_cause_t fault_cause_i,
  input  logic                    reset_clear_i,
  output logic                    fault_active_o,
  output logic                    clear_o,
  output logic                    reset_req_o,
  output logic                    irq_o,
  output guard_pkg::fault_cause_t fault_cause_o
);

  import guard_pkg::*;

  logic         reset_req_q;
  logic         irq_q;
  fault_cause_t cause_q;

  // Clear only acts on a pending fault
  assign clear_o        = reset_clear_i & reset_req_q;
  assign fault_active_o = reset_req_q;
  assign reset_req_o    = reset_req_q;
  assign irq_o          = irq_q;
  assign fault_cause_o  = cause_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reset_req_q <= 1'b0;
      irq_q       <= 1'b0;
      cause_q     <= '0;
    end else if (clear_o) begin
      reset_req_q <= 1'b0;
      irq_q       <= 1'b0;
      cause_q     <= '0;
    end else begin
      irq_q <= fault_valid_i & ~reset_req_q;  // Only on the rising request
      if (fault_valid_i) begin
        reset_req_q <= 1'b1;
        cause_q     <= cause_q | fault_cause_i;  // Sticky causes
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/write_guard.sv
// Write transaction guard
// Watches the AW and B channels of one manager and one subordinate and
// requests a reset when a write times out or a response has no write

`timescale 1ns/1ps
`default_nettype none

module write_guard #(
  parameter int unsigned MaxWrTxns    = 4,
  parameter int unsigned PrescalerDiv = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Manager AW
  input  logic                    mst_aw_valid_i,
  input  wr_bus_pkg::id_t         mst_aw_id_i,
  input  wr_bus_pkg::len_t        mst_aw_len_i,
  output logic                    mst_aw_ready_o,
  // Subordinate AW ready and the observed B channel
  input  logic                    slv_aw_ready_i,
  input  logic                    b_valid_i,
  input  logic                    b_ready_i,
  input  wr_bus_pkg::id_t         b_id_i,
  // Control
  input  guard_pkg::budget_t      budget_unit_i,
  input  logic                    reset_clear_i,
  output logic                    reset_req_o,
  output logic                    irq_o,
  output guard_pkg::fault_cause_t fault_cause_o
);

  import wr_bus_pkg::*;
  import guard_pkg::*;

  logic         enq_valid;
  id_t          enq_id;
  budget_t      enq_budget;
  logic         table_full;
  logic         fault_valid;
  fault_cause_t fault_cause;
  logic         fault_active;
  logic         table_clear;

  aw_monitor i_aw_monitor (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .mst_aw_valid_i ( mst_aw_valid_i ),
    .mst_aw_id_i    ( mst_aw_id_i    ),
    .mst_aw_len_i   ( mst_aw_len_i   ),
    .slv_aw_ready_i ( slv_aw_ready_i ),
    .budget_unit_i  ( budget_unit_i  ),
    .table_full_i   ( table_full     ),
    .fault_active_i ( fault_active   ),
    .mst_aw_ready_o ( mst_aw_ready_o ),
    .enq_valid_o    ( enq_valid      ),
    .enq_id_o       ( enq_id         ),
    .enq_budget_o   ( enq_budget     )
  );

  txn_table #(
    .MaxWrTxns    ( MaxWrTxns    ),
    .PrescalerDiv ( PrescalerDiv )
  ) i_txn_table (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .enq_valid_i   ( enq_valid   ),
    .enq_id_i      ( enq_id      ),
    .enq_budget_i  ( enq_budget  ),
    .b_valid_i     ( b_valid_i   ),
    .b_ready_i     ( b_ready_i   ),
    .b_id_i        ( b_id_i      ),
    .clear_i       ( table_clear ),
    .table_full_o  ( table_full  ),
    .fault_valid_o ( fault_valid ),
    .fault_cause_o ( fault_cause )
  );

  fault_handler i_fault_handler (
    .clk_i          ( clk_i         ),
    .rst_i          ( rst_i         ),
    .fault_valid_i  ( fault_valid   ),
    .fault_cause_i  ( fault_cause   ),
    .reset_clear_i  ( reset_clear_i ),
    .fault_active_o ( fault_active  ),
    .clear_o        ( table_clear   ),
    .reset_req_o    ( reset_req_o   ),
    .irq_o          ( irq_o         ),
    .fault_cause_o  ( fault_cause_o )
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the write guard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f write_guard.f \
  --top-module write_guard_tb \
  -o write_guard_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/write_guard_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

//--- test/write_guard_properties.sv
// Write guard properties
// Concurrent checks on the interrupt, reset request, clear and AW ready gating

`timescale 1ns/1ps
`default_nettype none

module write_guard_properties (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    mst_aw_ready_o,
  input logic                    slv_aw_ready_i,
  input logic                    reset_clear_i,
  input logic                    reset_req_o,
  input logic                    irq_o,
  input guard_pkg::fault_cause_t fault_cause_o
);

  int unsigned fail_cnt = 0;  // Failed assertion count

  // Interrupt lasts a single cycle
  irq_single: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_o |=> !irq_o)
    else begin
      fail_cnt++;
      $error("irq_o held for more than one cycle");
    end

  // Interrupt fires exactly when the request rises
  irq_on_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(reset_req_o) |-> irq_o)
    else begin
      fail_cnt++;
      $error("reset_req_o rose without irq_o");
    end

  irq_only_on_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_o |-> $rose(reset_req_o))
    else begin
      fail_cnt++;
      $error("irq_o without a new reset request");
    end

  // Request holds until software clears it
  req_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    (reset_req_o && !reset_clear_i) |=> reset_req_o)
    else begin
      fail_cnt++;
      $error("reset_req_o dropped without reset_clear_i");
    end

  req_cleared: assert property (@(posedge clk_i) disable iff (rst_i)
    (reset_req_o && reset_clear_i) |=> (!reset_req_o && fault_cause_o == '0))
    else begin
      fail_cnt++;
      $error("reset_clear_i did not clear the fault state");
    end

  // A pending request always carries a cause
  cause_matches_req: assert property (@(posedge clk_i) disable iff (rst_i)
    reset_req_o == (fault_cause_o != '0))
    else begin
      fail_cnt++;
      $error("fault_cause_o does not match reset_req_o");
    end

  aw_ready_gated: assert property (@(posedge clk_i) disable iff (rst_i)
    mst_aw_ready_o |-> (slv_aw_ready_i && !reset_req_o))
    else begin
      fail_cnt++;
      $error("mst_aw_ready_o high while it must be gated");
    end

  reset_state: assert property (@(posedge clk_i)
    rst_i |=> (!reset_req_o && !irq_o && fault_cause_o == '0))
    else begin
      fail_cnt++;
      $error("fault outputs not cleared by reset");
    end

endmodule

bind write_guard write_guard_properties i_properties (.*);

`default_nettype wire

//--- test/write_guard_tb.sv
// Write guard testbench
// Drives AW and B traffic through six phases covering in-budget writes,
// timeouts, unknown IDs, a full table and same-ID ordering

`timescale 1ns/1ps
`default_nettype none

module write_guard_tb;

  import wr_bus_pkg::*;
  import guard_pkg::*;

  localparam int unsigned MaxWrTxns    = 4;
  localparam int unsigned PrescalerDiv = 4;
  localparam int          BudgetUnit   = 8;
  localparam int          CycleLimit   = 2000;  // Six phases with margin over the longest budget

  logic         clk_i = 1'b0;
  logic         rst_i = 1'b1;
  logic         mst_aw_valid_i = 1'b0;
  id_t          mst_aw_id_i = '0;
  len_t         mst_aw_len_i = '0;
  logic         mst_aw_ready_o;
  logic         slv_aw_ready_i = 1'b1;
  logic         b_valid_i = 1'b0;
  logic         b_ready_i = 1'b1;
  id_t          b_id_i = '0;
  budget_t      budget_unit_i = budget_t'(BudgetUnit);
  logic         reset_clear_i = 1'b0;
  logic         reset_req_o;
  logic         irq_o;
  fault_cause_t fault_cause_o;

  int cycles = 0;
  id_t outstanding [$];  // IDs still waiting for a response

  write_guard #(
    .MaxWrTxns    ( MaxWrTxns    ),
    .PrescalerDiv ( PrescalerDiv )
  ) UUT (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run exceeded %0d cycles", CycleLimit);
      $display("Test FAILED");
      $fatal(1);
    end else if (UUT.i_properties.fail_cnt != 0) begin
      $display("A bound assertion failed");
      $display("Test FAILED");
      $fatal(1);
    end
  end

  task automatic check(input logic cond, input string msg);
    if (!cond) begin
      $display("error at %0t: %s", $time, msg);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Returns at the edge where the AW handshake happens
  task automatic aw_write(input id_t id, input len_t len);
    @(posedge clk_i);
    mst_aw_valid_i <= 1'b1;
    mst_aw_id_i    <= id;
    mst_aw_len_i   <= len;
    do begin
      @(negedge clk_i);
    end while (!mst_aw_ready_o);
    @(posedge clk_i);
    mst_aw_valid_i <= 1'b0;
  endtask

  // Handshake on the second edge
  task automatic b_resp(input id_t id);
    @(posedge clk_i);
    b_valid_i <= 1'b1;
    b_id_i    <= id;
    @(posedge clk_i);
    b_valid_i <= 1'b0;
  endtask

  // Edges counted until reset_req_o is seen high
  task automatic wait_fault(output int n);
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      @(negedge clk_i);
    end while (!reset_req_o);
  endtask

  task automatic clear_fault();
    check(irq_o == 1'b1, "irq_o not raised with the fault");
    @(negedge clk_i);
    check(irq_o == 1'b0, "irq_o longer than one cycle");
    @(posedge clk_i);
    reset_clear_i <= 1'b1;
    @(posedge clk_i);
    reset_clear_i <= 1'b0;
    @(negedge clk_i);
    check(!reset_req_o && fault_cause_o == '0, "fault not cleared");
  endtask

  // Expected timeout window for a write with the given length
  task automatic check_timeout(input int n, input int len);
    int budget;
    budget = BudgetUnit + len;
    check(n > budget * PrescalerDiv, "timeout before budget elapsed");
    check(n <= (budget + 2) * PrescalerDiv + 2, "timeout later than bound");
    check(fault_cause_o == 2'b10, "cause is not timeout");
  endtask

  initial begin
    int   n;
    int   idx;
    id_t  id;
    void'($urandom(32'hee7e_873f));
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // Interleaved writes answered in time
    for (int i = 0; i < 4; i++) begin
      id = id_t'($urandom % 16);
      aw_write(id, len_t'($urandom % 4));
      outstanding.push_back(id);
    end
    while (outstanding.size() > 0) begin
      idx = int'($urandom % outstanding.size());
      b_resp(outstanding[idx]);
      outstanding.delete(idx);
    end
    repeat (5) @(negedge clk_i);
    check(!reset_req_o, "fault on writes answered in time");

    // Unanswered write times out
    aw_write(id_t'(5), len_t'(2));
    wait_fault(n);
    check_timeout(n, 2);
    clear_fault();

    // Response with no write
    @(posedge clk_i);
    b_valid_i <= 1'b1;
    b_id_i    <= id_t'(7);
    @(negedge clk_i);
    check(!reset_req_o, "reset_req_o before the B handshake");
    @(posedge clk_i);
    b_valid_i <= 1'b0;
    @(negedge clk_i);
    check(reset_req_o && fault_cause_o == 2'b01, "unknown ID not flagged");
    clear_fault();

    // Full table holds AW ready low
    for (int i = 0; i < MaxWrTxns; i++) begin
      aw_write(id_t'(i), len_t'(0));
    end
    repeat (3) begin
      @(negedge clk_i);
      check(slv_aw_ready_i && !mst_aw_ready_o, "AW ready high with full table");
    end
    b_resp(id_t'(0));
    @(negedge clk_i);
    check(mst_aw_ready_o, "AW ready not reopened after a response");
    for (int i = 1; i < MaxWrTxns; i++) begin
      b_resp(id_t'(i));
    end
    @(negedge clk_i);
    check(!reset_req_o, "fault while draining the table");

    // First response frees the older write of an ID
    aw_write(id_t'(9), len_t'(10));
    aw_write(id_t'(9), len_t'(0));
    b_resp(id_t'(9));
    wait_fault(n);
    check_timeout(n + 2, 0);
    clear_fault();

    // Writes accepted again after the clear
    aw_write(id_t'(3), len_t'(1));
    b_resp(id_t'(3));
    repeat (3) @(negedge clk_i);
    check(!reset_req_o, "fault after clear on a good write");

    if (UUT.i_properties.fail_cnt == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- txn_table/txn_prescaler.sv
// Tick prescaler
// Modulo counter that gives one tick cycle in every PrescalerDiv clocks

`timescale 1ns/1ps
`default_nettype none

module txn_prescaler #(
  parameter int unsigned PrescalerDiv = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  output logic tick_o
);

  localparam int unsigned CntWidth = $clog2(PrescalerDiv);

  logic [CntWidth-1:0] cnt_q;

  assign tick_o = (cnt_q == CntWidth'(PrescalerDiv - 1));  // Last cycle of the period

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (tick_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- txn_table/txn_table.sv
// Outstanding write table
// Tracks every accepted write with its ID, budget, age and its rank among
// writes of the same ID. Releases on B responses and flags faults

`timescale 1ns/1ps
`default_nettype none

module txn_table #(
  parameter int unsigned MaxWrTxns    = 4,
  parameter int unsigned PrescalerDiv = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    enq_valid_i,
  input  wr_bus_pkg::id_t         enq_id_i,
  input  guard_pkg::budget_t      enq_budget_i,
  input  logic                    b_valid_i,
  input  logic                    b_ready_i,
  input  wr_bus_pkg::id_t         b_id_i,
  input  logic                    clear_i,
  output logic                    table_full_o,
  output logic                    fault_valid_o,
  output guard_pkg::fault_cause_t fault_cause_o
);

  import wr_bus_pkg::*;
  import guard_pkg::*;

  localparam int unsigned IdxWidth = idx_width(MaxWrTxns);

  typedef logic [IdxWidth-1:0] idx_t;

  // Entry state
  logic [MaxWrTxns-1:0] occ_q;
  id_t                  id_q     [MaxWrTxns];
  budget_t              budget_q [MaxWrTxns];
  age_t                 age_q    [MaxWrTxns];
  idx_t                 seq_q    [MaxWrTxns];  // Zero marks the oldest of its ID

  logic                 tick;
  logic                 b_hs;
  logic                 pend_hit;
  logic                 unknown_id;
  logic                 enq_take;
  logic [MaxWrTxns-1:0] b_hit;
  logic [MaxWrTxns-1:0] timed_out;
  logic [MaxWrTxns-1:0] release_vec;
  idx_t                 alloc_idx;
  idx_t                 enq_seq;
  idx_t                 seq_next [MaxWrTxns];

  txn_prescaler #(
    .PrescalerDiv ( PrescalerDiv )
  ) i_prescaler (
    .clk_i  ( clk_i ),
    .rst_i  ( rst_i ),
    .tick_o ( tick  )
  );

  assign b_hs = b_valid_i & b_ready_i;

  // Response matching and timeout detection per entry
  always_comb begin
    for (int j = 0; j < MaxWrTxns; j++) begin
      b_hit[j]     = b_hs & occ_q[j] & (id_q[j] == b_id_i) & (seq_q[j] == '0);
      timed_out[j] = occ_q[j] & (age_q[j] > {1'b0, budget_q[j]});
    end
  end

  // A response may also answer the write still waiting to be entered
  assign pend_hit    = b_hs & ~|b_hit & enq_valid_i & (enq_id_i == b_id_i);
  assign unknown_id  = b_hs & ~|b_hit & ~pend_hit;
  assign enq_take    = enq_valid_i & ~pend_hit;
  assign release_vec = b_hit | timed_out;

  // Lowest free slot, and the new write's rank behind the survivors of its ID
  always_comb begin
    int cnt;
    cnt       = 0;
    alloc_idx = '0;
    for (int j = MaxWrTxns - 1; j >= 0; j--) begin
      if (!occ_q[j]) alloc_idx = idx_t'(j);
    end
    for (int j = 0; j < MaxWrTxns; j++) begin
      if (occ_q[j] && !release_vec[j] && (id_q[j] == enq_id_i)) cnt++;
    end
    enq_seq = idx_t'(cnt);
  end

  // Survivors move up by the number of older same-ID entries released
  always_comb begin
    int dec;
    for (int j = 0; j < MaxWrTxns; j++) begin
      dec = 0;
      for (int i = 0; i < MaxWrTxns; i++) begin
        if (release_vec[i] && (id_q[i] == id_q[j]) && (seq_q[i] < seq_q[j])) dec++;
      end
      seq_next[j] = seq_q[j] - idx_t'(dec);
    end
  end

  // Full also counts a request that has not landed yet
  always_comb begin
    int free_cnt;
    free_cnt = 0;
    for (int j = 0; j < MaxWrTxns; j++) begin
      if (!occ_q[j]) free_cnt++;
    end
    table_full_o = (free_cnt == 0) || ((free_cnt == 1) && enq_valid_i);
  end

  assign fault_valid_o            = |timed_out | unknown_id;
  assign fault_cause_o.timeout    = |timed_out;
  assign fault_cause_o.unknown_id = unknown_id;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      occ_q <= '0;
    end else if (clear_i) begin
      occ_q <= '0;  // Software cleared the fault
    end else begin
      occ_q <= occ_q & ~release_vec;
      if (enq_take) begin
        occ_q[alloc_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int j = 0; j < MaxWrTxns; j++) begin
      if (tick && occ_q[j]) age_q[j] <= age_q[j] + 1'b1;
      seq_q[j] <= seq_next[j];
    end
    if (enq_take) begin
      id_q[alloc_idx]     <= enq_id_i;
      budget_q[alloc_idx] <= enq_budget_i;
      age_q[alloc_idx]    <= '0;   // Fresh write starts at zero
      seq_q[alloc_idx]    <= enq_seq;
    end
  end

endmodule

`default_nettype wire

//--- write_guard.f
common/wr_bus_pkg.sv
common/guard_pkg.sv
txn_table/txn_prescaler.sv
txn_table/txn_table.sv
logic/aw_monitor.sv
logic/fault_handler.sv
logic/write_guard.sv
test/write_guard_properties.sv
test/write_guard_tb.sv
